// File: verilog/lc3b_pkg.sv
package lc3b_pkg;

typedef logic [15:0] lc3b_word;
typedef logic [2:0]  lc3b_reg;
typedef logic [2:0]  lc3b_nzp;    // one-hot {n, z, p}
typedef logic [15:0] lc3b_instr;  // raw instruction word

// only the operate group is decoded
typedef enum logic [3:0]
{
    op_add = 4'b0001,
    op_and = 4'b0101,
    op_not = 4'b1001,
    op_shf = 4'b1101
} lc3b_opcode;

typedef enum logic [2:0]
{
    alu_add,
    alu_and,
    alu_not,
    alu_sll,
    alu_srl,
    alu_sra
} lc3b_aluop;

// control word built in ID and carried through EX
typedef struct packed
{
    lc3b_aluop  aluop;
    logic       imm_enable;    // operand b from sext(imm5)
    logic       shf_enable;    // operand b from zext(amount4)
    logic       load_regfile;
    lc3b_reg    dest;
    lc3b_reg    sr1;
    lc3b_reg    sr2;
    logic [4:0] imm5;          // amount4 sits in the low bits
} lc3b_ctrl;

// WB payload, also what the retire port shows
typedef struct packed
{
    logic     write;
    lc3b_reg  dest;
    lc3b_word value;
    lc3b_nzp  nzp;
} lc3b_retire;

endpackage : lc3b_pkg

// File: verilog/lc3b_stage_reg.sv
`timescale 1ns/1ns

module lc3b_stage_reg
#(
    parameter type payload_t = logic
)
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     load,
    input  logic     in_valid,
    input  payload_t in,
    output logic     out_valid,
    output payload_t out
);

always_ff @(posedge clk)
begin
    if (!rst_n)
    begin
        out_valid <= 1'b0;
        out <= '0;
    end
    else if (load)         // otherwise hold the entry
    begin
        out_valid <= in_valid;
        out <= in;
    end
end

endmodule : lc3b_stage_reg

// File: verilog/lc3b_regfile.sv
`timescale 1ns/1ns

module lc3b_regfile
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              write,
    input  lc3b_pkg::lc3b_reg  dest,
    input  lc3b_pkg::lc3b_word value,
    input  lc3b_pkg::lc3b_reg  src_a,
    input  lc3b_pkg::lc3b_reg  src_b,
    output lc3b_pkg::lc3b_word reg_a,
    output lc3b_pkg::lc3b_word reg_b
);

lc3b_pkg::lc3b_word regs [8];

always_ff @(posedge clk)
begin
    if (!rst_n)
    begin
        for (int i = 0; i < 8; i++)
            regs[i] <= '0;      // R0..R7 start at zero
    end
    else if (write)
    begin
        regs[dest] <= value;
    end
end

// read ports see the old value in the cycle of a write
assign reg_a = regs[src_a];
assign reg_b = regs[src_b];

endmodule : lc3b_regfile

// File: verilog/lc3b_execute.sv
`timescale 1ns/1ns

module lc3b_execute
(
    input  lc3b_pkg::lc3b_ctrl   ctrl,
    input  lc3b_pkg::lc3b_word   reg_a,
    input  lc3b_pkg::lc3b_word   reg_b,
    input  logic                 fwd_a,
    input  logic                 fwd_b,
    input  lc3b_pkg::lc3b_word   wb_value,
    output lc3b_pkg::lc3b_retire result
);

lc3b_pkg::lc3b_word opnd_a;
lc3b_pkg::lc3b_word sr2_val;
lc3b_pkg::lc3b_word opnd_b;
lc3b_pkg::lc3b_word sext5;
lc3b_pkg::lc3b_word zext4;
lc3b_pkg::lc3b_word alu_out;

assign sext5 = {{11{ctrl.imm5[4]}}, ctrl.imm5};
assign zext4 = {12'b0, ctrl.imm5[3:0]};     // shift amount

// WB value wins over a stale regfile read
assign opnd_a = fwd_a ? wb_value : reg_a;
assign sr2_val = fwd_b ? wb_value : reg_b;

always_comb
begin
    if (ctrl.shf_enable)
        opnd_b = zext4;
    else if (ctrl.imm_enable)
        opnd_b = sext5;
    else
        opnd_b = sr2_val;
end

always_comb
begin
    case (ctrl.aluop)
        lc3b_pkg::alu_add: alu_out = opnd_a + opnd_b;
        lc3b_pkg::alu_and: alu_out = opnd_a & opnd_b;
        lc3b_pkg::alu_not: alu_out = ~opnd_a;
        lc3b_pkg::alu_sll: alu_out = opnd_a << opnd_b[3:0];
        lc3b_pkg::alu_srl: alu_out = opnd_a >> opnd_b[3:0];
        lc3b_pkg::alu_sra: alu_out = $signed(opnd_a) >>> opnd_b[3:0];  // keeps the sign
        default:           alu_out = opnd_a;
    endcase
end

always_comb
begin
    result.write = ctrl.load_regfile;
    result.dest = ctrl.dest;
    result.value = alu_out;
    // condition codes from the result
    result.nzp[2] = alu_out[15];
    result.nzp[1] = (alu_out == 16'h0000);
    result.nzp[0] = !alu_out[15] && (alu_out != 16'h0000);
end

endmodule : lc3b_execute

// File: verilog/lc3b_control.sv
`timescale 1ns/1ns

module lc3b_control
(
    input  lc3b_pkg::lc3b_instr  id_instr,
    input  logic                 id_valid,
    input  lc3b_pkg::lc3b_ctrl   ex_ctrl,
    input  logic                 ex_valid,
    input  lc3b_pkg::lc3b_retire wb_retire,
    input  logic                 wb_valid,
    input  logic                 retire_ready,
    output logic                 advance,
    output lc3b_pkg::lc3b_ctrl   id_ctrl,
    output logic                 fwd_a,
    output logic                 fwd_b
);

logic known_op;
logic wb_writes;

always_comb
begin
    id_ctrl = '0;
    id_ctrl.aluop = lc3b_pkg::alu_add;
    id_ctrl.dest = id_instr[11:9];
    id_ctrl.sr1 = id_instr[8:6];
    id_ctrl.sr2 = id_instr[2:0];
    id_ctrl.imm5 = id_instr[4:0];
    known_op = 1'b1;
    case (lc3b_pkg::lc3b_opcode'(id_instr[15:12]))
        lc3b_pkg::op_add: id_ctrl.imm_enable = id_instr[5];    // bit 5 picks imm5
        lc3b_pkg::op_and:
        begin
            id_ctrl.aluop = lc3b_pkg::alu_and;
            id_ctrl.imm_enable = id_instr[5];
        end
        lc3b_pkg::op_not: id_ctrl.aluop = lc3b_pkg::alu_not;
        lc3b_pkg::op_shf:
        begin
            id_ctrl.shf_enable = 1'b1;
            case (id_instr[5:4])                           // {A, D}
                2'b01:   id_ctrl.aluop = lc3b_pkg::alu_srl;
                2'b11:   id_ctrl.aluop = lc3b_pkg::alu_sra;
                default: id_ctrl.aluop = lc3b_pkg::alu_sll;
            endcase
        end
        default: known_op = 1'b0;
    endcase
    id_ctrl.load_regfile = id_valid && known_op;  // bubbles and junk never write
end

// whole pipe moves together unless retire is blocked
assign advance = !wb_valid || retire_ready;

// WB is the only source that can be newer than the regfile
assign wb_writes = wb_valid && wb_retire.write;
assign fwd_a = ex_valid && wb_writes && (wb_retire.dest == ex_ctrl.sr1);
assign fwd_b = ex_valid && wb_writes && (wb_retire.dest == ex_ctrl.sr2);

endmodule : lc3b_control

// File: verilog/lc3b_core.sv
`timescale 1ns/1ns

module lc3b_core
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 instr_valid,
    output logic                 instr_ready,
    input  lc3b_pkg::lc3b_instr  instr,
    output logic                 retire_valid,
    input  logic                 retire_ready,
    output lc3b_pkg::lc3b_retire retire
);

logic advance;
logic id_valid;
logic ex_valid;
logic fwd_a;
logic fwd_b;
logic rf_write;

lc3b_pkg::lc3b_instr  id_instr;
lc3b_pkg::lc3b_ctrl   id_ctrl;
lc3b_pkg::lc3b_ctrl   ex_ctrl;
lc3b_pkg::lc3b_retire ex_result;
lc3b_pkg::lc3b_word   reg_a;
lc3b_pkg::lc3b_word   reg_b;

assign instr_ready = advance;
assign rf_write = retire_valid && retire_ready && retire.write;   // write on retire

lc3b_control control_i
(
    .id_instr(id_instr),
    .id_valid(id_valid),
    .ex_ctrl(ex_ctrl),
    .ex_valid(ex_valid),
    .wb_retire(retire),
    .wb_valid(retire_valid),
    .retire_ready(retire_ready),
    .advance(advance),
    .id_ctrl(id_ctrl),
    .fwd_a(fwd_a),
    .fwd_b(fwd_b)
);

lc3b_stage_reg #(.payload_t(lc3b_pkg::lc3b_instr)) id_stage
(
    .clk(clk),
    .rst_n(rst_n),
    .load(advance),
    .in_valid(instr_valid),
    .in(instr),
    .out_valid(id_valid),
    .out(id_instr)
);

lc3b_stage_reg #(.payload_t(lc3b_pkg::lc3b_ctrl)) ex_stage
(
    .clk(clk),
    .rst_n(rst_n),
    .load(advance),
    .in_valid(id_valid),
    .in(id_ctrl),
    .out_valid(ex_valid),
    .out(ex_ctrl)
);

lc3b_regfile regfile_i
(
    .clk(clk),
    .rst_n(rst_n),
    .write(rf_write),
    .dest(retire.dest),
    .value(retire.value),
    .src_a(ex_ctrl.sr1),       // read in EX
    .src_b(ex_ctrl.sr2),
    .reg_a(reg_a),
    .reg_b(reg_b)
);

lc3b_execute execute_i
(
    .ctrl(ex_ctrl),
    .reg_a(reg_a),
    .reg_b(reg_b),
    .fwd_a(fwd_a),
    .fwd_b(fwd_b),
    .wb_value(retire.value),
    .result(ex_result)
);

// WB entry drives the retire port directly
lc3b_stage_reg #(.payload_t(lc3b_pkg::lc3b_retire)) wb_stage
(
    .clk(clk),
    .rst_n(rst_n),
    .load(advance),
    .in_valid(ex_valid),
    .in(ex_result),
    .out_valid(retire_valid),
    .out(retire)
);

endmodule : lc3b_core

// File: bench/tb_clock.sv
`timescale 1ns/1ns

module tb_clock
(
    output logic clk,
    output logic rst_n
);

initial
begin
    clk = 1'b0;
    forever #4 clk = ~clk;         // 8 ns period
end

initial
begin
    rst_n = 1'b0;
    repeat (5) @(posedge clk);     // five reset edges
    @(negedge clk);
    rst_n = 1'b1;
end

endmodule : tb_clock

// File: bench/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

task automatic check_retire(input string name, input lc3b_pkg::lc3b_retire exp_r,
                            input lc3b_pkg::lc3b_retire act_r);
    checks++;
    if (act_r !== exp_r)
    begin
        $display("mismatch %s: expected w%b r%0d %h nzp %b, actual w%b r%0d %h nzp %b",
                 name, exp_r.write, exp_r.dest, exp_r.value, exp_r.nzp,
                 act_r.write, act_r.dest, act_r.value, act_r.nzp);
        errors++;
    end
endtask

task automatic check_word(input string name, input lc3b_pkg::lc3b_word exp_w,
                          input lc3b_pkg::lc3b_word act_w);
    checks++;
    if (act_w !== exp_w)
    begin
        $display("mismatch %s: expected %h, actual %h", name, exp_w, act_w);
        errors++;
    end
endtask

// single-bit port or field, such as a ready or the write bit
task automatic check_bit(input string name, input logic exp_b, input logic act_b);
    checks++;
    if (act_b !== exp_b)
    begin
        $display("mismatch %s: expected %b, actual %b", name, exp_b, act_b);
        errors++;
    end
endtask

// register form, bit 5 clear
function automatic lc3b_pkg::lc3b_instr reg_form(input lc3b_pkg::lc3b_opcode op,
    input lc3b_pkg::lc3b_reg dr, input lc3b_pkg::lc3b_reg sr1, input lc3b_pkg::lc3b_reg sr2);
    return {op, dr, sr1, 3'b000, sr2};
endfunction

function automatic lc3b_pkg::lc3b_instr imm_form(input lc3b_pkg::lc3b_opcode op,
    input lc3b_pkg::lc3b_reg dr, input lc3b_pkg::lc3b_reg sr1, input logic [4:0] imm5);
    return {op, dr, sr1, 1'b1, imm5};
endfunction

function automatic lc3b_pkg::lc3b_instr not_form(input lc3b_pkg::lc3b_reg dr,
                                                 input lc3b_pkg::lc3b_reg sr);
    return {lc3b_pkg::op_not, dr, sr, 6'h3f};
endfunction

// kind is {A, D}: 00 lshf, 01 rshfl, 11 rshfa
function automatic lc3b_pkg::lc3b_instr shift_instr(input lc3b_pkg::lc3b_reg dr,
    input lc3b_pkg::lc3b_reg sr, input logic [1:0] kind, input logic [3:0] amount);
    return {lc3b_pkg::op_shf, dr, sr, kind, amount};
endfunction

`endif

// File: bench/lc3b_core_tb.sv
`timescale 1ns/1ns

module lc3b_core_tb;

localparam int n_instr = 62;                   // instructions over all tests
localparam int cycle_limit = 20 * n_instr + 200;

logic clk;
logic rst_n;
logic instr_valid;
logic instr_ready;
logic retire_valid;
logic retire_ready;
lc3b_pkg::lc3b_instr  instr;
lc3b_pkg::lc3b_retire retire;
lc3b_pkg::lc3b_retire last;                    // most recent retire seen
lc3b_pkg::lc3b_word   model [8];               // reference register file
lc3b_pkg::lc3b_instr  stream [$];
int errors = 0;
int checks = 0;
int tests_run = 0;
int cycles = 0;
int seed = 39;

`include "tb_checks.svh"

tb_clock clock_i (.clk(clk), .rst_n(rst_n));

lc3b_core lc3b_core_i (.*);

always @(posedge clk)
begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit)
    begin
        $display("timeout: no retire arrived within %0d cycles", cycle_limit);
        $display("tests failed");
        $finish;
    end
end

// expected retire of one operate instruction, updates the model
function automatic lc3b_pkg::lc3b_retire predict(input lc3b_pkg::lc3b_instr ins);
    lc3b_pkg::lc3b_word a;
    lc3b_pkg::lc3b_word b;
    lc3b_pkg::lc3b_word v;
    lc3b_pkg::lc3b_retire r;
    a = model[ins[8:6]];
    b = ins[5] ? 16'($signed(ins[4:0])) : model[ins[2:0]];
    r.write = 1'b1;
    case (ins[15:12])
        4'b0001: v = a + b;
        4'b0101: v = a & b;
        4'b1001: v = ~a;
        4'b1101:
        begin
            case (ins[5:4])
                2'b01:   v = a >> ins[3:0];
                2'b11:   v = $signed(a) >>> ins[3:0];   // sign fill
                default: v = a << ins[3:0];
            endcase
        end
        default:
        begin
            v = '0;
            r.write = 1'b0;                           // not an operate instruction
        end
    endcase
    r.dest = ins[11:9];
    r.value = v;
    if (v[15])
        r.nzp = 3'b100;
    else if (v == 16'h0000)
        r.nzp = 3'b010;
    else
        r.nzp = 3'b001;
    if (r.write)
        model[r.dest] = v;
    return r;
endfunction

function automatic bit rand_bit();
    return ($random(seed) & 1) != 0;
endfunction

function automatic lc3b_pkg::lc3b_instr random_operate();
    logic [15:0] r;
    r = 16'($random(seed));
    case (r[15:14])
        2'd0:    return {lc3b_pkg::op_add, r[11:0]};
        2'd1:    return {lc3b_pkg::op_and, r[11:0]};
        2'd2:    return not_form(r[11:9], r[8:6]);
        default: return {lc3b_pkg::op_shf, r[11:0]};
    endcase
endfunction

// sends the queued stream and checks every retire in order
task automatic run_stream(input string name, input bit jitter);
    lc3b_pkg::lc3b_retire exp_q [$];
    lc3b_pkg::lc3b_retire exp_r;
    int sent;
    int got;
    int errs_before;
    bit held;
    sent = 0;
    got = 0;
    held = 1'b0;
    errs_before = errors;
    while (got < stream.size())
    begin
        @(negedge clk);
        if (!held)
            instr_valid = (sent < stream.size()) && (!jitter || rand_bit());
        if (sent < stream.size())
            instr = stream[sent];
        retire_ready = !jitter || rand_bit();
        #1;                                       // both handshakes settled here
        if (retire_valid && !retire_ready)
            check_bit(name, 1'b0, instr_ready);   // blocked retire stalls the pipe
        held = instr_valid && !instr_ready;       // offer stays up until taken
        if (instr_valid && instr_ready)
        begin
            exp_q.push_back(predict(stream[sent]));
            sent++;
        end
        if (retire_valid && retire_ready)
        begin
            got++;
            last = retire;
            if (exp_q.size() == 0)
            begin
                $display("%s: a retire came out with no instruction outstanding", name);
                errors++;
            end
            else
            begin
                exp_r = exp_q.pop_front();
                if (exp_r.write)
                    check_retire(name, exp_r, retire);
                else
                    check_bit(name, 1'b0, retire.write);
            end
        end
    end
    retire_ready = 1'b1;
    tests_run++;
    $display("%s: %0d instructions, %0d errors", name, stream.size(), errors - errs_before);
    stream.delete();
endtask

task automatic cleared_regs();
    #1;
    check_bit("cleared_regs", 1'b0, retire_valid);
    check_bit("cleared_regs", 1'b1, instr_ready);
    stream.push_back(imm_form(lc3b_pkg::op_add, 3'd1, 3'd0, 5'd0));
    run_stream("cleared_regs", 1'b0);
endtask

task automatic add_and_forms();
    stream.push_back(imm_form(lc3b_pkg::op_add, 3'd2, 3'd0, 5'd7));
    stream.push_back(imm_form(lc3b_pkg::op_add, 3'd3, 3'd0, 5'h1d));   // -3
    stream.push_back(reg_form(lc3b_pkg::op_add, 3'd4, 3'd2, 3'd3));
    stream.push_back(imm_form(lc3b_pkg::op_and, 3'd5, 3'd3, 5'h1a));   // -6
    stream.push_back(reg_form(lc3b_pkg::op_and, 3'd6, 3'd2, 3'd4));
    stream.push_back(imm_form(lc3b_pkg::op_and, 3'd7, 3'd2, 5'd0));
    run_stream("add_and_forms", 1'b0);
endtask

task automatic not_and_shifts();
    stream.push_back(not_form(3'd1, 3'd3));
    stream.push_back(shift_instr(3'd2, 3'd2, 2'b00, 4'd4));
    stream.push_back(shift_instr(3'd4, 3'd3, 2'b01, 4'd2));
    stream.push_back(shift_instr(3'd5, 3'd3, 2'b11, 4'd1));
    stream.push_back(shift_instr(3'd6, 3'd5, 2'b11, 4'd15));
    run_stream("not_and_shifts", 1'b0);
endtask

task automatic dependent_chain();
    stream.push_back(imm_form(lc3b_pkg::op_add, 3'd1, 3'd0, 5'd1));
    stream.push_back(reg_form(lc3b_pkg::op_add, 3'd1, 3'd1, 3'd1));
    stream.push_back(reg_form(lc3b_pkg::op_add, 3'd1, 3'd1, 3'd1));
    stream.push_back(imm_form(lc3b_pkg::op_add, 3'd2, 3'd1, 5'd5));
    stream.push_back(reg_form(lc3b_pkg::op_and, 3'd3, 3'd2, 3'd1));
    stream.push_back(not_form(3'd3, 3'd3));
    run_stream("dependent_chain", 1'b0);
endtask

task automatic random_stream();
    for (int i = 0; i < 40; i++)
        stream.push_back(random_operate());
    run_stream("random_stream", 1'b1);
endtask

// BR encoding is outside the decoded set
task automatic unknown_opcode();
    stream.push_back(imm_form(lc3b_pkg::op_and, 3'd6, 3'd6, 5'd0));
    stream.push_back(imm_form(lc3b_pkg::op_add, 3'd6, 3'd6, 5'd9));
    stream.push_back({4'b0000, 3'd6, 9'h1ff});
    stream.push_back(imm_form(lc3b_pkg::op_add, 3'd7, 3'd6, 5'd0));
    run_stream("unknown_opcode", 1'b0);
    check_word("unknown_opcode", 16'd9, last.value);
endtask

initial
begin
    instr_valid = 1'b0;
    instr = '0;
    retire_ready = 1'b1;
    for (int i = 0; i < 8; i++)
        model[i] = '0;
    @(posedge rst_n);
    cleared_regs();
    add_and_forms();
    not_and_shifts();
    dependent_chain();
    random_stream();
    unknown_opcode();
    $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0)
        $display("all tests passed");
    else
        $display("tests failed");
    $finish;
end

endmodule : lc3b_core_tb

// File: project.f
+incdir+bench
verilog/lc3b_pkg.sv
verilog/lc3b_stage_reg.sv
verilog/lc3b_regfile.sv
verilog/lc3b_execute.sv
verilog/lc3b_control.sv
verilog/lc3b_core.sv
bench/tb_clock.sv
bench/lc3b_core_tb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing
TOP       = lc3b_core_tb
RTL_TOP   = lc3b_core
FILELIST  = project.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "all tests passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
